// ==== lbcPkg.sv ====
package lbcPkg;

  // Bus widths
  localparam int AddrW = 32;
  localparam int DataW = 32;
  localparam int BeW = DataW / 8; // One enable per byte lane

  // System memory
  localparam int MemLatency = 2; // Request sample to valid strobe
  localparam int MemWords = 256;
  localparam int MemIdxW = $clog2(MemWords); // Word index taken from address bits 9 to 2

  // Access size carried with every data request
  typedef enum logic [1:0]
  {
    accByte = 2'b00,
    accHalf = 2'b01,
    accWord = 2'b10
  } accSizeT;

  // Request generator states
  typedef enum logic [1:0]
  {
    reqIdle = 2'b00,
    reqData = 2'b01, // Data access outstanding
    reqInst = 2'b10  // Fetch outstanding
  } reqStateT;

endpackage

// ==== lbcBusReq.sv ====
module lbcBusReq
(
  input  logic                     IDCLOCKI,
  input  logic                     reset,
  input  logic                     dRead,
  input  logic                     dWrite,
  input  logic [lbcPkg::AddrW-1:0] dAddr,
  input  lbcPkg::accSizeT          dSize,
  input  logic                     dSign,
  input  logic [lbcPkg::BeW-1:0]   dBe,
  input  logic                     iFetch,
  input  logic [lbcPkg::AddrW-1:0] iAddr,
  input  logic                     dDone,
  input  logic                     iDone,
  output logic                     busy,
  output logic                     sysDReq,
  output logic                     sysDRw,
  output logic [lbcPkg::AddrW-1:0] sysDAddr,
  output lbcPkg::accSizeT          sysDSize,
  output logic [lbcPkg::BeW-1:0]   sysDBe,
  output logic                     sysDSign,
  output logic                     sysIReq,
  output logic [lbcPkg::AddrW-1:0] sysIAddr
);

  lbcPkg::reqStateT         state;
  logic                     iPend;
  logic [lbcPkg::AddrW-1:0] iPendAddr;

  assign busy = (state != lbcPkg::reqIdle);

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
    begin
      state <= lbcPkg::reqIdle;
      sysDReq <= 1'b0;
      sysDRw <= 1'b0;
      sysDAddr <= '0;
      sysDSize <= lbcPkg::accByte;
      sysDBe <= '0;
      sysDSign <= 1'b0;
      sysIReq <= 1'b0;
      sysIAddr <= '0;
      iPend <= 1'b0;
      iPendAddr <= '0;
    end
    else
    begin
      sysDReq <= 1'b0; // Requests are single-cycle pulses
      sysIReq <= 1'b0;
      case (state)
        lbcPkg::reqIdle:
        begin
          if (dRead || dWrite)
          begin
            sysDReq <= 1'b1;
            sysDRw <= dWrite;
            sysDAddr <= dAddr;
            sysDSize <= dSize;
            sysDBe <= dBe;
            sysDSign <= dSign;
            iPend <= iFetch; // Fetch waits behind the data access
            iPendAddr <= iAddr;
            state <= lbcPkg::reqData;
          end
          else if (iFetch)
          begin
            sysIReq <= 1'b1;
            sysIAddr <= iAddr;
            state <= lbcPkg::reqInst;
          end
        end
        lbcPkg::reqData:
        begin
          // A write is done once issued, a read once its data returns
          if (sysDRw || dDone)
          begin
            if (iPend)
            begin
              sysIReq <= 1'b1;
              sysIAddr <= iPendAddr;
              iPend <= 1'b0;
              state <= lbcPkg::reqInst;
            end
            else
            begin
              state <= lbcPkg::reqIdle;
            end
          end
        end
        lbcPkg::reqInst:
        begin
          if (iDone)
          begin
            state <= lbcPkg::reqIdle;
          end
        end
        default:
        begin
          state <= lbcPkg::reqIdle;
        end
      endcase
    end
  end

  // Core side holds off new strobes while an access is outstanding
  strobeWhileBusy: assert property (@(posedge IDCLOCKI) disable iff (reset)
    busy |-> !(dRead || dWrite || iFetch));

  // Data request is a lone pulse and never overlaps a fetch request
  reqExclusive: assert property (@(posedge IDCLOCKI) disable iff (reset)
    sysDReq |-> !sysIReq ##1 !sysDReq);

endmodule

// ==== lbcLoadAlign.sv ====
module lbcLoadAlign
(
  input  lbcPkg::accSizeT          sizeIn,
  input  logic                     sign,
  input  logic [1:0]               offset,
  input  logic [lbcPkg::DataW-1:0] din,
  output logic [lbcPkg::DataW-1:0] dout
);

  logic [7:0]  laneByte;
  logic [15:0] laneHalf;
  logic        extByte;
  logic        extHalf;

  always_comb
  begin
    laneByte = din[{offset, 3'b000} +: 8]; // Byte lane picked by offset
    laneHalf = offset[1] ? din[31:16] : din[15:0];
    extByte = sign & laneByte[7];
    extHalf = sign & laneHalf[15];
  end

  always_comb
  begin
    case (sizeIn)
      lbcPkg::accByte:
      begin
        dout = {{(lbcPkg::DataW - 8){extByte}}, laneByte};
      end
      lbcPkg::accHalf:
      begin
        dout = {{(lbcPkg::DataW - 16){extHalf}}, laneHalf};
      end
      default:
      begin
        dout = din; // Full word passes through
      end
    endcase
  end

endmodule

// ==== lbcLocalBus.sv ====
module lbcLocalBus
(
  input  logic                     IDCLOCKI,
  input  logic                     reset,
  input  logic                     dRead,
  input  logic                     dWrite,
  input  logic [lbcPkg::AddrW-1:0] dAddr,
  input  lbcPkg::accSizeT          dSize,
  input  logic                     dSign,
  input  logic [lbcPkg::BeW-1:0]   dBe,
  input  logic [lbcPkg::DataW-1:0] dWData,
  input  logic                     iFetch,
  input  logic [lbcPkg::AddrW-1:0] iAddr,
  input  logic                     sysDVal,
  input  logic [lbcPkg::DataW-1:0] sysDData,
  input  logic                     sysIVal,
  input  logic [lbcPkg::DataW-1:0] sysIData,
  input  logic                     sysWbEmpty,
  output logic                     busy,
  output logic                     dVal,
  output logic [lbcPkg::DataW-1:0] dRData,
  output logic                     iVal,
  output logic [lbcPkg::DataW-1:0] iData,
  output logic                     wbEmpty,
  output logic                     sysDReq,
  output logic                     sysDRw,
  output logic [lbcPkg::AddrW-1:0] sysDAddr,
  output lbcPkg::accSizeT          sysDSize,
  output logic [lbcPkg::BeW-1:0]   sysDBe,
  output logic [lbcPkg::DataW-1:0] sysDo,
  output logic                     sysIReq,
  output logic [lbcPkg::AddrW-1:0] sysIAddr
);

  logic                     sysDSign;
  lbcPkg::accSizeT          dSizeQ;
  logic                     dSignQ;
  logic [1:0]               dOffsetQ;
  logic                     dValQ;
  logic                     iValQ;
  logic [lbcPkg::DataW-1:0] dDataQ;
  logic [lbcPkg::DataW-1:0] iDataQ;

  lbcBusReq u_lbcBusReq
  (
    .IDCLOCKI (IDCLOCKI),
    .reset    (reset),
    .dRead    (dRead),
    .dWrite   (dWrite),
    .dAddr    (dAddr),
    .dSize    (dSize),
    .dSign    (dSign),
    .dBe      (dBe),
    .iFetch   (iFetch),
    .iAddr    (iAddr),
    .dDone    (dValQ),
    .iDone    (iValQ),
    .busy     (busy),
    .sysDReq  (sysDReq),
    .sysDRw   (sysDRw),
    .sysDAddr (sysDAddr),
    .sysDSize (sysDSize),
    .sysDBe   (sysDBe),
    .sysDSign (sysDSign),
    .sysIReq  (sysIReq),
    .sysIAddr (sysIAddr)
  );

  lbcLoadAlign u_lbcLoadAlign
  (
    .sizeIn (dSizeQ),
    .sign   (dSignQ),
    .offset (dOffsetQ),
    .din    (dDataQ),
    .dout   (dRData)
  );

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
    begin
      dSizeQ <= lbcPkg::accByte;
      dSignQ <= 1'b0;
      dOffsetQ <= 2'b00;
    end
    else if (sysDReq)
    begin
      dSizeQ <= sysDSize; // Held until the load data comes back
      dSignQ <= sysDSign;
      dOffsetQ <= sysDAddr[1:0];
    end
  end

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
    begin
      sysDo <= '0;
      wbEmpty <= 1'b0;
      dValQ <= 1'b0;
      iValQ <= 1'b0;
      dDataQ <= '0;
      iDataQ <= '0;
    end
    else
    begin
      sysDo <= dWData; // Lines up with sysDReq
      wbEmpty <= sysWbEmpty;
      dValQ <= sysDVal;
      iValQ <= sysIVal;
      dDataQ <= sysDData;
      iDataQ <= sysIData;
    end
  end

  assign dVal = dValQ;
  assign iVal = iValQ;
  assign iData = iDataQ;

endmodule

// ==== lbcSysMemory.sv ====
module lbcSysMemory
(
  input  logic                     IDCLOCKI,
  input  logic                     reset,
  input  logic                     sysDReq,
  input  logic                     sysDRw,
  input  logic [lbcPkg::AddrW-1:0] sysDAddr,
  input  lbcPkg::accSizeT          sysDSize,
  input  logic [lbcPkg::BeW-1:0]   sysDBe,
  input  logic [lbcPkg::DataW-1:0] sysDo,
  input  logic                     sysIReq,
  input  logic [lbcPkg::AddrW-1:0] sysIAddr,
  output logic                     sysDVal,
  output logic [lbcPkg::DataW-1:0] sysDData,
  output logic                     sysIVal,
  output logic [lbcPkg::DataW-1:0] sysIData,
  output logic                     sysWbEmpty
);

  logic [lbcPkg::DataW-1:0]   mem [lbcPkg::MemWords];
  logic                       clrActive;
  logic [lbcPkg::MemIdxW-1:0] clrAddr;
  logic                       wbValid;
  logic [lbcPkg::MemIdxW-1:0] wbIdx;
  logic [lbcPkg::BeW-1:0]     wbBe;
  logic [lbcPkg::DataW-1:0]   wbData;
  logic [lbcPkg::BeW-1:0]     laneMask;
  logic [lbcPkg::MemIdxW-1:0] dIdx;
  logic [lbcPkg::MemIdxW-1:0] iIdx;
  logic [lbcPkg::MemLatency:0] dValPipe;
  logic [lbcPkg::MemLatency:0] iValPipe;
  logic [lbcPkg::DataW-1:0]   dDataPipe [lbcPkg::MemLatency+1];
  logic [lbcPkg::DataW-1:0]   iDataPipe [lbcPkg::MemLatency+1];

  // Array word with any buffered bytes laid over it
  function automatic logic [lbcPkg::DataW-1:0] readWord(input logic [lbcPkg::MemIdxW-1:0] idx);
    logic [lbcPkg::DataW-1:0] word;
    word = mem[idx];
    if (wbValid && (wbIdx == idx))
    begin
      for (int b = 0; b < lbcPkg::BeW; b++)
      begin
        if (wbBe[b])
        begin
          word[8*b +: 8] = wbData[8*b +: 8];
        end
      end
    end
    return word;
  endfunction

  assign dIdx = sysDAddr[lbcPkg::MemIdxW+1:2];
  assign iIdx = sysIAddr[lbcPkg::MemIdxW+1:2];

  always_comb
  begin
    case (sysDSize)
      lbcPkg::accByte: laneMask = 4'b0001 << sysDAddr[1:0];
      lbcPkg::accHalf: laneMask = sysDAddr[1] ? 4'b1100 : 4'b0011;
      default:         laneMask = 4'b1111;
    endcase
  end

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
    begin
      clrActive <= 1'b1;
      clrAddr <= '0;
    end
    else if (clrActive)
    begin
      clrAddr <= clrAddr + 1'b1; // One word per cycle
      if (clrAddr == lbcPkg::MemIdxW'(lbcPkg::MemWords - 1))
      begin
        clrActive <= 1'b0;
      end
    end
  end

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
    begin
      wbValid <= 1'b0;
      wbIdx <= '0;
      wbBe <= '0;
      wbData <= '0;
    end
    else
    begin
      wbValid <= sysDReq & sysDRw; // Buffered entry retires next cycle
      if (sysDReq && sysDRw)
      begin
        wbIdx <= dIdx;
        wbBe <= sysDBe & laneMask;
        wbData <= sysDo;
      end
    end
  end

  always_ff @(posedge IDCLOCKI)
  begin
    if (clrActive)
    begin
      mem[clrAddr] <= '0;
    end
    else if (wbValid)
    begin
      for (int b = 0; b < lbcPkg::BeW; b++)
      begin
        if (wbBe[b])
        begin
          mem[wbIdx][8*b +: 8] <= wbData[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
    begin
      dValPipe <= '0;
      iValPipe <= '0;
      for (int k = 0; k <= lbcPkg::MemLatency; k++)
      begin
        dDataPipe[k] <= '0;
        iDataPipe[k] <= '0;
      end
    end
    else
    begin
      dValPipe <= {dValPipe[lbcPkg::MemLatency-1:0], sysDReq & ~sysDRw};
      iValPipe <= {iValPipe[lbcPkg::MemLatency-1:0], sysIReq};
      dDataPipe[0] <= readWord(dIdx); // Full word always, aligner picks the lane
      iDataPipe[0] <= readWord(iIdx);
      for (int k = 1; k <= lbcPkg::MemLatency; k++)
      begin
        dDataPipe[k] <= dDataPipe[k-1];
        iDataPipe[k] <= iDataPipe[k-1];
      end
    end
  end

  assign sysDVal = dValPipe[lbcPkg::MemLatency];
  assign sysDData = dDataPipe[lbcPkg::MemLatency];
  assign sysIVal = iValPipe[lbcPkg::MemLatency];
  assign sysIData = iDataPipe[lbcPkg::MemLatency];
  assign sysWbEmpty = ~wbValid;

endmodule

// ==== lbcSubsystem.sv ====
module lbcSubsystem
(
  input  logic                     IDCLOCKI,
  input  logic                     reset,
  input  logic                     dRead,
  input  logic                     dWrite,
  input  logic [lbcPkg::AddrW-1:0] dAddr,
  input  lbcPkg::accSizeT          dSize,
  input  logic                     dSign,
  input  logic [lbcPkg::BeW-1:0]   dBe,
  input  logic [lbcPkg::DataW-1:0] dWData,
  input  logic                     iFetch,
  input  logic [lbcPkg::AddrW-1:0] iAddr,
  output logic                     busy,
  output logic                     dVal,
  output logic [lbcPkg::DataW-1:0] dRData,
  output logic                     iVal,
  output logic [lbcPkg::DataW-1:0] iData,
  output logic                     wbEmpty
);

  logic                     sysDReq;
  logic                     sysDRw;
  logic [lbcPkg::AddrW-1:0] sysDAddr;
  lbcPkg::accSizeT          sysDSize;
  logic [lbcPkg::BeW-1:0]   sysDBe;
  logic [lbcPkg::DataW-1:0] sysDo;
  logic                     sysIReq;
  logic [lbcPkg::AddrW-1:0] sysIAddr;
  logic                     sysDVal;
  logic [lbcPkg::DataW-1:0] sysDData;
  logic                     sysIVal;
  logic [lbcPkg::DataW-1:0] sysIData;
  logic                     sysWbEmpty;

  lbcLocalBus u_lbcLocalBus
  (
    .IDCLOCKI   (IDCLOCKI),
    .reset      (reset),
    .dRead      (dRead),
    .dWrite     (dWrite),
    .dAddr      (dAddr),
    .dSize      (dSize),
    .dSign      (dSign),
    .dBe        (dBe),
    .dWData     (dWData),
    .iFetch     (iFetch),
    .iAddr      (iAddr),
    .sysDVal    (sysDVal),
    .sysDData   (sysDData),
    .sysIVal    (sysIVal),
    .sysIData   (sysIData),
    .sysWbEmpty (sysWbEmpty),
    .busy       (busy),
    .dVal       (dVal),
    .dRData     (dRData),
    .iVal       (iVal),
    .iData      (iData),
    .wbEmpty    (wbEmpty),
    .sysDReq    (sysDReq),
    .sysDRw     (sysDRw),
    .sysDAddr   (sysDAddr),
    .sysDSize   (sysDSize),
    .sysDBe     (sysDBe),
    .sysDo      (sysDo),
    .sysIReq    (sysIReq),
    .sysIAddr   (sysIAddr)
  );

  lbcSysMemory u_lbcSysMemory
  (
    .IDCLOCKI   (IDCLOCKI),
    .reset      (reset),
    .sysDReq    (sysDReq),
    .sysDRw     (sysDRw),
    .sysDAddr   (sysDAddr),
    .sysDSize   (sysDSize),
    .sysDBe     (sysDBe),
    .sysDo      (sysDo),
    .sysIReq    (sysIReq),
    .sysIAddr   (sysIAddr),
    .sysDVal    (sysDVal),
    .sysDData   (sysDData),
    .sysIVal    (sysIVal),
    .sysIData   (sysIData),
    .sysWbEmpty (sysWbEmpty)
  );

endmodule

// ==== tbLbc.sv ====
module tbLbc;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ResetCycles = 10;
  localparam int LoadDelay = 4; // Acceptance edge to dVal or unconflicted iVal
  localparam int RoundTrips = 40;
  localparam int SubWords = 6;
  localparam int Fetches = 16;
  localparam int Conflicts = 8;
  localparam int WbWrites = 16;
  // Write 3 cycles, read or fetch 7, conflict pair 12, checked write 6
  localparam int TestCycles = ResetCycles + lbcPkg::MemWords + RoundTrips * 10
    + SubWords * (3 * 3 + 12 * 7) + Fetches * 7 + Conflicts * 12 + WbWrites * 6;
  localparam int CycleLimit = 2 * TestCycles;

  logic                     IDCLOCKI;
  logic                     reset;
  logic                     dRead;
  logic                     dWrite;
  logic [lbcPkg::AddrW-1:0] dAddr;
  lbcPkg::accSizeT          dSize;
  logic                     dSign;
  logic [lbcPkg::BeW-1:0]   dBe;
  logic [lbcPkg::DataW-1:0] dWData;
  logic                     iFetch;
  logic [lbcPkg::AddrW-1:0] iAddr;
  logic                     busy;
  logic                     dVal;
  logic [lbcPkg::DataW-1:0] dRData;
  logic                     iVal;
  logic [lbcPkg::DataW-1:0] iData;
  logic                     wbEmpty;

  logic [lbcPkg::DataW-1:0] model [lbcPkg::MemWords];
  logic [lbcPkg::DataW-1:0] dExpQ[$];
  logic [lbcPkg::DataW-1:0] iExpQ[$];
  int                       dAccQ[$];
  int                       iAccQ[$]; // -1 where the fetch has no fixed delay
  string                    dNameQ[$];
  string                    iNameQ[$];
  int                       dTaken = 0;
  int                       iTaken = 0;
  int                       cycle = 0;
  int                       acceptCycle;
  int                       lastDCycle = 0;
  int                       lastICycle = 0;
  int                       compareErrors = 0;
  int                       stimErrors = 0;

  lbcSubsystem u_lbcSubsystem
  (
    .IDCLOCKI (IDCLOCKI),
    .reset    (reset),
    .dRead    (dRead),
    .dWrite   (dWrite),
    .dAddr    (dAddr),
    .dSize    (dSize),
    .dSign    (dSign),
    .dBe      (dBe),
    .dWData   (dWData),
    .iFetch   (iFetch),
    .iAddr    (iAddr),
    .busy     (busy),
    .dVal     (dVal),
    .dRData   (dRData),
    .iVal     (iVal),
    .iData    (iData),
    .wbEmpty  (wbEmpty)
  );

  initial
  begin
    IDCLOCKI = 1'b0;
    forever #20 IDCLOCKI = ~IDCLOCKI;
  end

  always @(posedge IDCLOCKI)
  begin
    cycle <= cycle + 1;
  end

  // Returns 1 on a mismatch so each process keeps its own count
  function automatic int checkValue(input string name, input logic [31:0] expected,
                                    input logic [31:0] actual);
    int bad;
    bad = 0;
    assert (actual == expected) else
    begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      bad = 1;
    end
    return bad;
  endfunction

  // Lane picked by offset, then widened with the lane's top bit or zeros
  function automatic logic [31:0] expectedLoad(input logic [31:0] word,
                                               input lbcPkg::accSizeT size,
                                               input logic [1:0] offset, input logic sign);
    logic [31:0] lane;
    logic [31:0] result;
    lane = word >> (8 * offset);
    if (size == lbcPkg::accByte)
    begin
      result = (sign && lane[7]) ? (lane | 32'hffffff00) : (lane & 32'h000000ff);
    end
    else if (size == lbcPkg::accHalf)
    begin
      result = (sign && lane[15]) ? (lane | 32'hffff0000) : (lane & 32'h0000ffff);
    end
    else
    begin
      result = word;
    end
    return result;
  endfunction

  function automatic logic [31:0] randomWordAddr();
    logic [31:0] addr;
    addr = '0;
    addr[lbcPkg::MemIdxW+1:2] = lbcPkg::MemIdxW'($urandom_range(lbcPkg::MemWords - 1));
    return addr;
  endfunction

  // Strobes once busy is low, returns at the negedge after the acceptance edge
  task automatic issueAccess(input logic rd, input logic wr, input logic [31:0] addr,
                             input lbcPkg::accSizeT size, input logic sign,
                             input logic [3:0] be, input logic [31:0] wdata,
                             input logic fetch, input logic [31:0] fetchAddr);
    do
    begin
      @(negedge IDCLOCKI);
    end
    while (busy);
    @(posedge IDCLOCKI);
    dRead <= rd;
    dWrite <= wr;
    dAddr <= addr;
    dSize <= size;
    dSign <= sign;
    dBe <= be;
    dWData <= wdata;
    iFetch <= fetch;
    iAddr <= fetchAddr;
    @(posedge IDCLOCKI);
    dRead <= 1'b0;
    dWrite <= 1'b0;
    iFetch <= 1'b0;
    @(negedge IDCLOCKI);
    acceptCycle = cycle;
  endtask

  task automatic writeWord(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data);
    issueAccess(1'b0, 1'b1, addr, lbcPkg::accWord, 1'b0, be, data, 1'b0, '0);
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
      begin
        model[addr[lbcPkg::MemIdxW+1:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic loadCheck(input logic [31:0] addr, input lbcPkg::accSizeT size,
                           input logic sign, input string name);
    issueAccess(1'b1, 1'b0, addr, size, sign, 4'hf, '0, 1'b0, '0);
    dExpQ.push_back(expectedLoad(model[addr[lbcPkg::MemIdxW+1:2]], size, addr[1:0], sign));
    dAccQ.push_back(acceptCycle);
    dNameQ.push_back(name);
  endtask

  task automatic fetchCheck(input logic [31:0] addr);
    issueAccess(1'b0, 1'b0, '0, lbcPkg::accWord, 1'b0, 4'h0, '0, 1'b1, addr);
    iExpQ.push_back(model[addr[lbcPkg::MemIdxW+1:2]]);
    iAccQ.push_back(acceptCycle);
    iNameQ.push_back("instruction fetch");
  endtask

  task automatic conflictCheck(input logic [31:0] addr, input logic [31:0] fetchAddr);
    issueAccess(1'b1, 1'b0, addr, lbcPkg::accWord, 1'b0, 4'hf, '0, 1'b1, fetchAddr);
    dExpQ.push_back(model[addr[lbcPkg::MemIdxW+1:2]]);
    dAccQ.push_back(acceptCycle);
    dNameQ.push_back("conflict load");
    iExpQ.push_back(model[fetchAddr[lbcPkg::MemIdxW+1:2]]);
    iAccQ.push_back(-1); // Fetch waits for the data return
    iNameQ.push_back("conflict fetch");
    while (dTaken != dExpQ.size() || iTaken != iExpQ.size())
    begin
      @(negedge IDCLOCKI);
    end
    if (lastICycle <= lastDCycle)
    begin
      $display("The fetch returned before the data read it was strobed with");
      stimErrors++;
    end
  endtask

  task automatic writeBufferCheck(input logic [31:0] addr, input logic [31:0] data);
    writeWord(addr, 4'hf, data);
    stimErrors += checkValue("write busy", 32'd1, 32'(busy));
    @(negedge IDCLOCKI);
    stimErrors += checkValue("write busy released", 32'd0, 32'(busy));
    @(negedge IDCLOCKI);
    stimErrors += checkValue("wbEmpty low", 32'd0, 32'(wbEmpty));
    @(negedge IDCLOCKI);
    stimErrors += checkValue("wbEmpty high", 32'd1, 32'(wbEmpty));
  endtask

  // Every return is matched in order against what the stimulus expects
  always @(negedge IDCLOCKI)
  begin
    if (!reset)
    begin
      assert (!(busy && (dRead || dWrite || iFetch))) else
      begin
        $display("A core strobe was driven while busy was high");
        compareErrors++;
      end
      if (dVal)
      begin
        if (dTaken >= dExpQ.size())
        begin
          $display("dVal pulsed with no load outstanding");
          compareErrors++;
        end
        else
        begin
          lastDCycle = cycle;
          compareErrors += checkValue(dNameQ[dTaken], dExpQ[dTaken], dRData);
          compareErrors += checkValue({dNameQ[dTaken], " delay"}, LoadDelay,
                                      cycle - dAccQ[dTaken]);
          dTaken++;
        end
      end
      if (iVal)
      begin
        if (iTaken >= iExpQ.size())
        begin
          $display("iVal pulsed with no fetch outstanding");
          compareErrors++;
        end
        else
        begin
          lastICycle = cycle;
          compareErrors += checkValue(iNameQ[iTaken], iExpQ[iTaken], iData);
          if (iAccQ[iTaken] >= 0)
          begin
            compareErrors += checkValue({iNameQ[iTaken], " delay"}, LoadDelay,
                                        cycle - iAccQ[iTaken]);
          end
          iTaken++;
        end
      end
    end
  end

  initial
  begin
    while (cycle < CycleLimit)
    begin
      @(negedge IDCLOCKI);
    end
    $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
    $display("Errors: %0d in returns, %0d in stimulus checks", compareErrors, stimErrors);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0] addr;
    void'($urandom(60));
    reset <= 1'b1;
    dRead <= 1'b0;
    dWrite <= 1'b0;
    dAddr <= '0;
    dSize <= lbcPkg::accWord;
    dSign <= 1'b0;
    dBe <= '0;
    dWData <= '0;
    iFetch <= 1'b0;
    iAddr <= '0;
    for (int w = 0; w < lbcPkg::MemWords; w++)
    begin
      model[w] = '0;
    end
    repeat (ResetCycles) @(posedge IDCLOCKI);
    reset <= 1'b0;
    @(posedge IDCLOCKI);
    @(negedge IDCLOCKI);
    stimErrors += checkValue("reset busy", 32'd0, 32'(busy));
    stimErrors += checkValue("reset dVal", 32'd0, 32'(dVal));
    stimErrors += checkValue("reset iVal", 32'd0, 32'(iVal));
    stimErrors += checkValue("reset wbEmpty", 32'd1, 32'(wbEmpty));
    repeat (lbcPkg::MemWords) @(posedge IDCLOCKI); // Memory clears one word per cycle

    for (int n = 0; n < RoundTrips; n++)
    begin
      addr = randomWordAddr();
      writeWord(addr, 4'hf, $urandom());
      loadCheck(addr, lbcPkg::accWord, 1'b0, "word round trip");
    end

    for (int n = 0; n < SubWords; n++)
    begin
      addr = randomWordAddr();
      for (int k = 0; k < 3; k++)
      begin
        writeWord(addr, 4'($urandom_range(15)), $urandom());
      end
      for (int off = 0; off < 4; off++)
      begin
        for (int sg = 0; sg < 2; sg++)
        begin
          loadCheck(addr + off, lbcPkg::accByte, sg[0], "byte load");
          if (off % 2 == 0)
          begin
            loadCheck(addr + off, lbcPkg::accHalf, sg[0], "halfword load");
          end
        end
      end
    end

    for (int n = 0; n < Fetches; n++)
    begin
      fetchCheck(randomWordAddr());
    end
    for (int n = 0; n < Conflicts; n++)
    begin
      conflictCheck(randomWordAddr(), randomWordAddr());
    end
    for (int n = 0; n < WbWrites; n++)
    begin
      writeBufferCheck(randomWordAddr(), $urandom());
    end

    while (dTaken != dExpQ.size() || iTaken != iExpQ.size() || busy)
    begin
      @(negedge IDCLOCKI);
    end
    repeat (4) @(negedge IDCLOCKI); // Catch any stray valid strobe
    $display("Errors: %0d in returns, %0d in stimulus checks", compareErrors, stimErrors);
    if (compareErrors == 0 && stimErrors == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
lbcPkg.sv
lbcBusReq.sv
lbcLoadAlign.sv
lbcLocalBus.sv
lbcSysMemory.sv
lbcSubsystem.sv
tbLbc.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tbLbc \
  -f sim.f -o simLbc > build.log 2>&1 &&
./obj_dir/simLbc > sim.log 2>&1
grep -qx "TEST OK" sim.log && echo "Simulation passed" && exit 0 ||
  { echo "Simulation failed, see build.log and sim.log"; exit 1; }
